// File: tileMemWrap.f
hdl/tileMemPkg.sv
hdl/dualPortRam.sv
hdl/transFifo.sv
hdl/instrFetch.sv
hdl/coreDataPath.sv
hdl/fabricTarget.sv
hdl/fabricEgress.sv
hdl/tileMemWrap.sv
verif/tbClockGen.sv
verif/tileMemWrap_asserts.sv
verif/tileMemWrapTb.sv

// File: Makefile
TOP := tileMemWrapTb

all: run

run:
	verilator --binary --timing --assert -j 0 -f tileMemWrap.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

lint:
	verilator --lint-only -Wall --timing -f tileMemWrap.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

// File: verif/tileMemWrapTb.sv
`timescale 1ns/1ps
`default_nettype none

module tileMemWrapTb;
   import tileMemPkg::*;

   localparam tileId LocalTile  = 8'h05;
   localparam tileId RemoteTile = 8'h22;
   localparam int    NumWords   = 8;
   // Rough sum of all test lengths times three
   localparam int CycleLimit = 3 * (6 + 3*NumWords + 6 + 3*NumWords + 2*NumWords + 4 + 10 + 20 + 30);

   logic     Clock;
   logic     arstN;
   logic     readyFetch;
   word      pc;
   word      instruction;
   word      dMemWrData;
   word      dMemAddress;
   byteEn    dMemByteEn;
   logic     dMemWrEn;
   logic     dMemRdEn;
   word      dMemRdRsp;
   logic     dMemReady;
   logic     inFabricValid;
   tileTrans inFabric;
   logic     fabricInReady;
   logic     outFabricValid;
   tileTrans outFabric;
   logic     fabReady;

   integer   seed;
   int       errorCount = 0;
   int       testErrors;     // Count at test start
   int       testCount  = 0;
   int       cycleCount = 0;
   string    testName;
   tileTrans sentQ [$];      // Everything seen leaving on the fabric

   tbClockGen uClockGen (
      .Clock (Clock),
      .arstN (arstN)
   );

   tileMemWrap u_tileMemWrap (
      .Clock          (Clock),
      .arstN          (arstN),
      .localTile      (LocalTile),
      .readyFetch     (readyFetch),
      .pc             (pc),
      .instruction    (instruction),
      .dMemWrData     (dMemWrData),
      .dMemAddress    (dMemAddress),
      .dMemByteEn     (dMemByteEn),
      .dMemWrEn       (dMemWrEn),
      .dMemRdEn       (dMemRdEn),
      .dMemRdRsp      (dMemRdRsp),
      .dMemReady      (dMemReady),
      .inFabricValid  (inFabricValid),
      .inFabric       (inFabric),
      .fabricInReady  (fabricInReady),
      .outFabricValid (outFabricValid),
      .outFabric      (outFabric),
      .fabReady       (fabReady)
   );

   // Fabric sink at mid-cycle so grant and data are settled
   always @(negedge Clock) begin
      if (arstN && outFabricValid) sentQ.push_back(outFabric);
   end

   always @(posedge Clock) begin
      cycleCount = cycleCount + 1;
      if (cycleCount >= CycleLimit) begin
         $display("Run stopped at cycle %0d, test %s did not finish", cycleCount, testName);
         $display("Result: FAILED");
         $finish;
      end
   end

   // ================================================
   // Helpers
   // ================================================
   task automatic nextCycle();
      @(posedge Clock);
      #1;                    // Drive and sample just after the edge
   endtask

   task automatic idleInputs();
      dMemWrEn      = 1'b0;
      dMemRdEn      = 1'b0;
      dMemWrData    = '0;
      dMemAddress   = '0;
      dMemByteEn    = '0;
      inFabricValid = 1'b0;
      inFabric      = '0;
   endtask

   task automatic mismatchWord(input string what, input word expected, input word actual);
      $display("CHECK FAILED %s, %s: expected %h, actual %h", testName, what, expected, actual);
      errorCount++;
   endtask

   task automatic mismatchTrans(input string what, input tileTrans expected,
                                input tileTrans actual);
      $display("CHECK FAILED %s, %s: expected %h, actual %h", testName, what, expected, actual);
      errorCount++;
   endtask

   task automatic reportProblem(input string what);
      $display("Test %s: %s", testName, what);
      errorCount++;
   endtask

   function automatic tileTrans makeTrans(input word adrs, input word data, input opcode op,
                                          input tileId requestor);
      tileTrans t;
      t.address     = adrs;
      t.data        = data;
      t.op          = op;
      t.requestorId = requestor;
      return t;
   endfunction

   task automatic startTest(input string name);
      testName   = name;
      testErrors = errorCount;
      testCount++;
      sentQ.delete();
   endtask

   task automatic endTest();
      $display("Test %s finished with %0d errors", testName, errorCount - testErrors);
   endtask

   task automatic waitCoreReady();
      int waited;
      waited = 0;
      while (!dMemReady && waited < 20) begin
         nextCycle();
         waited++;
      end
      if (!dMemReady) reportProblem("dMemReady never came back high");
   endtask

   task automatic waitSent(input int count);
      int waited;
      waited = 0;
      while (sentQ.size() < count && waited < 30) begin
         nextCycle();
         waited++;
      end
      if (sentQ.size() < count) reportProblem("expected fabric transaction never came out");
   endtask

   // One-cycle fabric transaction held off while the tile is full
   task automatic fabricSend(input tileTrans t);
      int waited;
      waited = 0;
      while (!fabricInReady && waited < 20) begin
         nextCycle();
         waited++;
      end
      if (!fabricInReady) reportProblem("fabricInReady never came back high");
      inFabricValid = 1'b1;
      inFabric      = t;
      nextCycle();
      inFabricValid = 1'b0;
   endtask

   task automatic coreWrite(input word adrs, input word data, input byteEn be);
      waitCoreReady();
      dMemAddress = adrs;
      dMemWrData  = data;
      dMemByteEn  = be;
      dMemWrEn    = 1'b1;
      nextCycle();
      idleInputs();
   endtask

   // Local read with data back at T+2
   task automatic coreRead(input word adrs, input byteEn be, output word data);
      waitCoreReady();
      dMemAddress = adrs;
      dMemByteEn  = be;
      dMemRdEn    = 1'b1;
      nextCycle();
      idleInputs();
      nextCycle();
      data = dMemRdRsp;
   endtask

   // ================================================
   // Tests
   // ================================================
   task automatic dataMemRoundTrip();
      word dModel [NumWords];
      word got;
      logic [7:0] b;
      startTest("dataMem");
      for (int i = 0; i < NumWords; i++) begin
         dModel[i] = $random(seed);
         coreWrite(32'h0000_0100 + 4*i, dModel[i], 4'hF);
      end
      for (int i = 0; i < NumWords; i++) begin
         coreRead(32'h0000_0100 + 4*i, 4'hF, got);
         if (got !== dModel[i]) mismatchWord("word read", dModel[i], got);
      end
      got = $random(seed);
      b   = got[7:0];
      coreWrite(32'h0000_0102, {24'h0, b}, 4'b0001);   // Lane 2 only
      dModel[0][23:16] = b;
      coreRead(32'h0000_0102, 4'b0001, got);
      if (got !== {24'h0, b}) mismatchWord("byte read offset 2", {24'h0, b}, got);
      coreRead(32'h0000_0100, 4'hF, got);                // Other lanes untouched
      if (got !== dModel[0]) mismatchWord("word after byte write", dModel[0], got);
      endTest();
   endtask

   task automatic instrLoadAndFetch();
      word iModel [NumWords];
      startTest("instrLoad");
      for (int i = 0; i < NumWords; i++) begin
         iModel[i] = $random(seed);
         fabricSend(makeTrans({LocalTile, 24'h00_0000} + 4*i, iModel[i], OpWr, RemoteTile));
      end
      readyFetch = 1'b1;
      for (int i = 0; i < NumWords; i++) begin
         pc = 4*i;
         nextCycle();
         if (instruction !== iModel[i]) mismatchWord("fetch", iModel[i], instruction);
      end
      pc = 32'd8;
      nextCycle();
      readyFetch = 1'b0;   // Stall while pc moves on
      pc         = 32'd20;
      for (int i = 0; i < 2; i++) begin
         nextCycle();
         if (instruction !== iModel[2]) mismatchWord("held fetch", iModel[2], instruction);
      end
      readyFetch = 1'b1;
      nextCycle();
      if (instruction !== iModel[5]) mismatchWord("fetch after stall", iModel[5], instruction);
      endTest();
   endtask

   task automatic whoAmIRead();
      word got;
      startTest("whoAmI");
      coreRead(WhoAmIAddr, 4'hF, got);
      if (got !== {24'h0, LocalTile}) mismatchWord("tile id", {24'h0, LocalTile}, got);
      endTest();
   endtask

   task automatic fabricReadBack();
      word      adrs;
      word      data;
      word      got;
      tileTrans expected;
      startTest("fabricRead");
      fabReady = 1'b1;
      adrs     = {LocalTile, 24'h10_0040};   // DMem region at word 0x10
      data     = $random(seed);
      fabricSend(makeTrans(adrs, data, OpWr, RemoteTile));
      fabricSend(makeTrans(adrs, 32'h0, OpRd, RemoteTile));
      waitSent(1);
      expected = makeTrans({RemoteTile, adrs[23:0]}, data, OpRdRsp, LocalTile);
      if (sentQ.size() > 0 && sentQ[0] !== expected) begin
         mismatchTrans("read response", expected, sentQ[0]);
      end
      coreRead(32'h0000_0040, 4'hF, got);     // Same word from the core side
      if (got !== data) mismatchWord("core view of fabric write", data, got);
      endTest();
   endtask

   task automatic remoteAccess();
      word      adrs;
      word      data;
      tileTrans expected;
      startTest("remote");
      fabReady = 1'b1;
      adrs     = {RemoteTile, 24'h00_0080};
      data     = $random(seed);
      coreWrite(adrs, data, 4'hF);
      waitSent(1);
      expected = makeTrans(adrs, data, OpWr, LocalTile);
      if (sentQ.size() > 0 && sentQ[0] !== expected) begin
         mismatchTrans("remote write", expected, sentQ[0]);
      end
      sentQ.delete();

      // Remote read freezes the core until the answer
      waitCoreReady();
      adrs        = {RemoteTile, 24'h00_0084};
      dMemAddress = adrs;
      dMemByteEn  = 4'hF;
      dMemRdEn    = 1'b1;
      nextCycle();
      idleInputs();
      if (dMemReady !== 1'b0) mismatchWord("dMemReady at T+1", 32'd0, 32'(dMemReady));
      waitSent(1);
      expected = makeTrans(adrs, 32'h0, OpRd, LocalTile);
      if (sentQ.size() > 0 && sentQ[0] !== expected) begin
         mismatchTrans("remote read", expected, sentQ[0]);
      end
      if (dMemReady !== 1'b0) mismatchWord("dMemReady while waiting", 32'd0, 32'(dMemReady));
      data = $random(seed);
      fabricSend(makeTrans({LocalTile, 24'h00_0084}, data, OpRdRsp, RemoteTile));
      if (dMemReady !== 1'b1) mismatchWord("dMemReady after response", 32'd1, 32'(dMemReady));
      nextCycle();                                // Data two cycles after arrival
      if (dMemRdRsp !== data) mismatchWord("remote read data", data, dMemRdRsp);
      endTest();
   endtask

   task automatic egressArbitration();
      word      rdAdrs;
      word      rdData;
      word      reqAdrs;
      word      reqData;
      tileTrans expRsp;
      tileTrans expReq;
      startTest("egress");
      fabReady = 1'b0;
      rdAdrs   = {LocalTile, 24'h10_00C0};
      rdData   = $random(seed);
      reqAdrs  = {RemoteTile, 24'h00_00C8};
      reqData  = $random(seed);
      fabricSend(makeTrans(rdAdrs, rdData, OpWr, RemoteTile));
      fabricSend(makeTrans(rdAdrs, 32'h0, OpRd, RemoteTile));
      coreWrite(reqAdrs, reqData, 4'hF);          // Both FIFOs now loaded
      repeat (6) nextCycle();
      if (sentQ.size() != 0) reportProblem("transaction sent while fabReady was low");
      if (fabricInReady !== 1'b0) mismatchWord("fabricInReady", 32'd0, 32'(fabricInReady));
      fabReady = 1'b1;
      waitSent(2);
      expRsp = makeTrans({RemoteTile, rdAdrs[23:0]}, rdData, OpRdRsp, LocalTile);
      expReq = makeTrans(reqAdrs, reqData, OpWr, LocalTile);
      if (sentQ.size() >= 2) begin
         // Last grant went to the remote read request so the response leads
         if (sentQ[0] !== expRsp) mismatchTrans("first grant", expRsp, sentQ[0]);
         if (sentQ[1] !== expReq) mismatchTrans("second grant", expReq, sentQ[1]);
      end
      if (fabricInReady !== 1'b1) mismatchWord("fabricInReady after drain", 32'd1,
                                               32'(fabricInReady));
      endTest();
   endtask

   // ================================================
   // Sequence
   // ================================================
   initial begin
      seed       = 32'h3234_4395;
      testName   = "reset";
      testErrors = 0;
      readyFetch = 1'b1;
      pc         = '0;
      fabReady   = 1'b1;
      idleInputs();
      @(posedge arstN);
      nextCycle();
      dataMemRoundTrip();
      instrLoadAndFetch();
      whoAmIRead();
      fabricReadBack();
      remoteAccess();
      egressArbitration();
      $display("Tests run: %0d, errors: %0d", testCount, errorCount);
      if (errorCount == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/tileMemWrap_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module tileMemWrapAsserts (
   input wire Clock,
   input wire arstN,
   input wire fabReady,
   input wire outFabricValid,
   input wire dMemReady
);

   // Egress only grants with fabric ready
   noSendWhileBlocked: assert property (@(posedge Clock) disable iff (!arstN)
      outFabricValid |-> fabReady)
      else $error("outFabricValid high while fabReady low");

   // Core may issue right out of reset
   readyAfterReset: assert property (@(posedge Clock) $rose(arstN) |-> dMemReady)
      else $error("dMemReady low in first cycle after reset");

endmodule

bind tileMemWrap tileMemWrapAsserts uAsserts (
   .Clock          (Clock),
   .arstN          (arstN),
   .fabReady       (fabReady),
   .outFabricValid (outFabricValid),
   .dMemReady      (dMemReady)
);

`default_nettype wire

// File: verif/tbClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module tbClockGen (
   output logic Clock,
   output logic arstN
);

   initial begin
      Clock = 1'b0;
      forever #4 Clock = ~Clock;   // 8 ns period
   end

   // Reset held for 5 rising edges, released just after the edge
   initial begin
      arstN = 1'b0;
      repeat (5) @(posedge Clock);
      #1 arstN = 1'b1;
   end

endmodule

`default_nettype wire

// File: hdl/tileMemWrap.sv
`timescale 1ns/1ps
`default_nettype none

module tileMemWrap (
   input  wire                      Clock,
   input  wire                      arstN,
   input  var tileMemPkg::tileId    localTile,
   // ================================================
   // Instruction fetch
   // ================================================
   input  wire                      readyFetch,
   input  var tileMemPkg::word      pc,
   output tileMemPkg::word          instruction,
   // ================================================
   // Data access
   // ================================================
   input  var tileMemPkg::word      dMemWrData,
   input  var tileMemPkg::word      dMemAddress,
   input  var tileMemPkg::byteEn    dMemByteEn,
   input  wire                      dMemWrEn,
   input  wire                      dMemRdEn,
   output tileMemPkg::word          dMemRdRsp,
   output logic                     dMemReady,
   // ================================================
   // Fabric
   // ================================================
   input  wire                      inFabricValid,
   input  var tileMemPkg::tileTrans inFabric,
   output logic                     fabricInReady,
   output logic                     outFabricValid,
   output tileMemPkg::tileTrans     outFabric,
   input  wire                      fabReady
);
   import tileMemPkg::*;

   fabWrite  fabWr;
   word      iMemFabRd;   // Port B read words
   word      dMemFabRd;
   logic     rspPush;
   tileTrans rspTrans;
   logic     reqPush;
   tileTrans reqTrans;
   logic     reqFull;

   instrFetch uInstrFetch (
      .Clock       (Clock),
      .arstN       (arstN),
      .readyFetch  (readyFetch),
      .pc          (pc),
      .instruction (instruction),
      .fabWr       (fabWr),
      .fabRdAdrs   (inFabric.address),
      .fabRdData   (iMemFabRd)
   );

   coreDataPath uCoreDataPath (
      .Clock         (Clock),
      .arstN         (arstN),
      .localTile     (localTile),
      .dMemWrData    (dMemWrData),
      .dMemAddress   (dMemAddress),
      .dMemByteEn    (dMemByteEn),
      .dMemWrEn      (dMemWrEn),
      .dMemRdEn      (dMemRdEn),
      .dMemRdRsp     (dMemRdRsp),
      .dMemReady     (dMemReady),
      .fabWr         (fabWr),
      .fabRdAdrs     (inFabric.address),
      .fabRdData     (dMemFabRd),
      .inFabricValid (inFabricValid),
      .inFabric      (inFabric),
      .reqPush       (reqPush),
      .reqTrans      (reqTrans),
      .reqFull       (reqFull)
   );

   fabricTarget uFabricTarget (
      .Clock         (Clock),
      .arstN         (arstN),
      .localTile     (localTile),
      .inFabricValid (inFabricValid),
      .inFabric      (inFabric),
      .fabWr         (fabWr),
      .iMemRdData    (iMemFabRd),
      .dMemRdData    (dMemFabRd),
      .rspPush       (rspPush),
      .rspTrans      (rspTrans)
   );

   fabricEgress uFabricEgress (
      .Clock          (Clock),
      .arstN          (arstN),
      .rspPush        (rspPush),
      .rspTrans       (rspTrans),
      .reqPush        (reqPush),
      .reqTrans       (reqTrans),
      .reqFull        (reqFull),
      .fabReady       (fabReady),
      .outFabricValid (outFabricValid),
      .outFabric      (outFabric),
      .fabricInReady  (fabricInReady)
   );

endmodule

`default_nettype wire

// File: hdl/fabricEgress.sv
`timescale 1ns/1ps
`default_nettype none

module fabricEgress (
   input  wire                      Clock,
   input  wire                      arstN,
   input  wire                      rspPush,
   input  var tileMemPkg::tileTrans rspTrans,
   input  wire                      reqPush,
   input  var tileMemPkg::tileTrans reqTrans,
   output logic                     reqFull,
   input  wire                      fabReady,
   output logic                     outFabricValid,
   output tileMemPkg::tileTrans     outFabric,
   output logic                     fabricInReady
);
   import tileMemPkg::*;

   tileTrans rspHead;
   tileTrans reqHead;
   logic     rspEmpty;
   logic     reqEmpty;
   logic     rspAlmostFull;
   logic     candRsp;
   logic     candReq;
   logic     grantRsp;
   logic     grantReq;
   logic     lastReq;   // Last grant went to the request FIFO

   // Read responses to the fabric
   transFifo rspFifo (
      .Clock      (Clock),
      .arstN      (arstN),
      .push       (rspPush),
      .pushData   (rspTrans),
      .pop        (grantRsp),
      .popData    (rspHead),
      .full       (),
      .almostFull (rspAlmostFull),
      .empty      (rspEmpty)
   );

   // Core requests to other tiles
   transFifo reqFifo (
      .Clock      (Clock),
      .arstN      (arstN),
      .push       (reqPush),
      .pushData   (reqTrans),
      .pop        (grantReq),
      .popData    (reqHead),
      .full       (reqFull),
      .almostFull (),
      .empty      (reqEmpty)
   );

   // ================================================
   // Round-robin arbiter
   // ================================================
   assign candRsp  = !rspEmpty && fabReady;
   assign candReq  = !reqEmpty && fabReady;
   assign grantReq = candReq && (!candRsp || !lastReq);   // Alternate when both wait
   assign grantRsp = candRsp && !grantReq;

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         lastReq <= 1'b0;
      end else if (grantRsp || grantReq) begin
         lastReq <= grantReq;
      end
   end

   assign outFabricValid = grantRsp || grantReq;
   assign outFabric      = grantRsp ? rspHead :
                           grantReq ? reqHead :
                                      '0;

   assign fabricInReady = !rspAlmostFull;   // Stop fabric a cycle early

endmodule

`default_nettype wire

// File: hdl/fabricTarget.sv
`timescale 1ns/1ps
`default_nettype none

module fabricTarget (
   input  wire                      Clock,
   input  wire                      arstN,
   input  var tileMemPkg::tileId    localTile,
   input  wire                      inFabricValid,
   input  var tileMemPkg::tileTrans inFabric,
   output tileMemPkg::fabWrite      fabWr,
   input  var tileMemPkg::word      iMemRdData,
   input  var tileMemPkg::word      dMemRdData,
   output logic                     rspPush,
   output tileMemPkg::tileTrans     rspTrans
);
   import tileMemPkg::*;

   logic [3:0] region;
   logic       iHit;
   logic       dHit;
   logic       isWr;
   logic       rdReq;
   logic       iHitQ1;
   logic       dHitQ1;
   word        rspAdrsQ1;

   assign region = inFabric.address[RegionMsb:RegionLsb];
   assign iHit   = (region == IMemRegion);
   assign dHit   = (region == DMemRegion);
   assign isWr   = inFabricValid && (inFabric.op == OpWr);
   assign rdReq  = inFabricValid && (inFabric.op == OpRd);

   // ================================================
   // Writes into local memories
   // ================================================
   always_comb begin
      fabWr.adrs     = inFabric.address;
      fabWr.data     = inFabric.data;
      fabWr.iMemWrEn = isWr && iHit;
      fabWr.dMemWrEn = isWr && dHit;
   end

   // ================================================
   // Read response, one cycle after the request
   // ================================================
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         rspPush <= 1'b0;
      end else begin
         rspPush <= rdReq;
      end
   end

   always_ff @(posedge Clock) begin
      iHitQ1    <= iHit;
      dHitQ1    <= dHit;
      rspAdrsQ1 <= {inFabric.requestorId, inFabric.address[23:0]};   // Back to requestor
   end

   always_comb begin
      rspTrans.address     = rspAdrsQ1;
      rspTrans.data        = iHitQ1 ? iMemRdData :   // IMEM wins
                             dHitQ1 ? dMemRdData :
                                      '0;
      rspTrans.op          = OpRdRsp;
      rspTrans.requestorId = localTile;
   end

endmodule

`default_nettype wire

// File: hdl/coreDataPath.sv
`timescale 1ns/1ps
`default_nettype none

module coreDataPath (
   input  wire                       Clock,
   input  wire                       arstN,
   input  var tileMemPkg::tileId     localTile,
   // Core side
   input  var tileMemPkg::word       dMemWrData,
   input  var tileMemPkg::word       dMemAddress,
   input  var tileMemPkg::byteEn     dMemByteEn,
   input  wire                       dMemWrEn,
   input  wire                       dMemRdEn,
   output tileMemPkg::word           dMemRdRsp,
   output logic                      dMemReady,
   // Fabric side of the memory
   input  var tileMemPkg::fabWrite   fabWr,
   input  var tileMemPkg::word       fabRdAdrs,
   output tileMemPkg::word           fabRdData,
   // Incoming responses
   input  wire                       inFabricValid,
   input  var tileMemPkg::tileTrans  inFabric,
   // Outgoing requests
   output logic                      reqPush,
   output tileMemPkg::tileTrans      reqTrans,
   input  wire                       reqFull
);
   import tileMemPkg::*;

   rdState     state;
   logic       isLocal;
   logic       localWrEn;
   logic       remoteReq;
   logic       whoAmI;
   logic       rspArrive;
   word        shiftWrData;
   byteEn      shiftByteEn;
   word        portBAdrs;
   word        memRaw;        // Port A, one cycle after request
   word        memAligned;
   word        rdSel;
   logic       whoAmIQ1;
   logic       rspValidQ1;
   word        rspDataQ1;
   logic [1:0] offQ1;         // Byte offset of the read
   byteEn      beQ1;

   // ================================================
   // Decode
   // ================================================
   assign isLocal   = (dMemAddress[31:24] == localTile) || (dMemAddress[31:24] == 8'h00);
   assign localWrEn = dMemWrEn && isLocal;
   assign remoteReq = (dMemWrEn || dMemRdEn) && !isLocal;
   assign whoAmI    = dMemRdEn && (dMemAddress == WhoAmIAddr);

   // Align to the byte lane
   assign shiftWrData = dMemWrData << {dMemAddress[1:0], 3'b000};
   assign shiftByteEn = dMemByteEn << dMemAddress[1:0];

   assign portBAdrs = fabWr.dMemWrEn ? fabWr.adrs : fabRdAdrs;

   dualPortRam dMem (
      .Clock   (Clock),
      .adrsA   (dMemAddress[MemAdrsW+1:2]),
      .wrDataA (shiftWrData),
      .byteEnA (shiftByteEn),
      .wrEnA   (localWrEn),
      .rdDataA (memRaw),
      .adrsB   (portBAdrs[MemAdrsW+1:2]),
      .wrDataB (fabWr.data),
      .wrEnB   (fabWr.dMemWrEn),
      .rdDataB (fabRdData)
   );

   // ================================================
   // Remote access
   // ================================================
   assign dMemReady = (state == Idle) && !reqFull;
   assign reqPush   = remoteReq && dMemReady;
   assign rspArrive = (state == WaitRsp) && inFabricValid && (inFabric.op == OpRdRsp);

   always_comb begin
      reqTrans.address     = dMemAddress;
      reqTrans.data        = dMemWrData;   // Unshifted, target aligns
      reqTrans.op          = dMemWrEn ? OpWr : OpRd;
      reqTrans.requestorId = localTile;
   end

   // Tracker, core frozen until the read response
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         state <= Idle;
      end else begin
         case (state)
            Idle: begin
               if (reqPush && dMemRdEn && !dMemWrEn) state <= WaitRsp;
            end
            WaitRsp: begin
               if (rspArrive) state <= Idle;
            end
            default: state <= Idle;
         endcase
      end
   end

   // ================================================
   // Read return, two cycles
   // ================================================
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         whoAmIQ1   <= 1'b0;
         rspValidQ1 <= 1'b0;
      end else begin
         whoAmIQ1   <= whoAmI;
         rspValidQ1 <= rspArrive;
      end
   end

   always_ff @(posedge Clock) begin
      rspDataQ1 <= inFabric.data;
      offQ1     <= dMemAddress[1:0];
      beQ1      <= dMemByteEn;
   end

   // Shift down, zero the lanes not asked for
   assign memAligned = (memRaw >> {offQ1, 3'b000}) &
                       {{8{beQ1[3]}}, {8{beQ1[2]}}, {8{beQ1[1]}}, {8{beQ1[0]}}};

   assign rdSel = rspValidQ1 ? rspDataQ1 :          // Older remote read first
                  whoAmIQ1   ? {24'h0, localTile} :
                               memAligned;

   always_ff @(posedge Clock) begin
      dMemRdRsp <= rdSel;   // Second stage
   end

endmodule

`default_nettype wire

// File: hdl/instrFetch.sv
`timescale 1ns/1ps
`default_nettype none

module instrFetch (
   input  wire                     Clock,
   input  wire                     arstN,
   input  wire                     readyFetch,
   input  var tileMemPkg::word     pc,
   output tileMemPkg::word         instruction,
   input  var tileMemPkg::fabWrite fabWr,
   input  var tileMemPkg::word     fabRdAdrs,
   output tileMemPkg::word         fabRdData
);
   import tileMemPkg::*;

   word  fetchWord;     // Raw RAM output
   word  lastFetch;     // Held while core stalls
   logic sampleReady;   // readyFetch one cycle late
   word  portBAdrs;

   // Port B follows the fabric write when there is one
   assign portBAdrs = fabWr.iMemWrEn ? fabWr.adrs : fabRdAdrs;

   dualPortRam iMem (
      .Clock   (Clock),
      .adrsA   (pc[MemAdrsW+1:2]),   // Word index
      .wrDataA ('0),
      .byteEnA ('0),
      .wrEnA   (1'b0),               // Core never writes
      .rdDataA (fetchWord),
      .adrsB   (portBAdrs[MemAdrsW+1:2]),
      .wrDataB (fabWr.data),
      .wrEnB   (fabWr.iMemWrEn),
      .rdDataB (fabRdData)
   );

   // ================================================
   // Fetch hold
   // ================================================
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         sampleReady <= 1'b0;
      end else begin
         sampleReady <= readyFetch;
      end
   end

   always_ff @(posedge Clock) begin
      if (sampleReady) lastFetch <= fetchWord;   // Keep last good fetch
   end

   assign instruction = sampleReady ? fetchWord : lastFetch;

endmodule

`default_nettype wire

// File: hdl/transFifo.sv
`timescale 1ns/1ps
`default_nettype none

module transFifo (
   input  wire                    Clock,
   input  wire                    arstN,
   input  wire                    push,
   input  var tileMemPkg::tileTrans pushData,
   input  wire                    pop,
   output tileMemPkg::tileTrans   popData,
   output logic                   full,
   output logic                   almostFull,
   output logic                   empty
);
   import tileMemPkg::*;

   tileTrans   entry [2];    // Two slots
   logic       wrPtr;
   logic       rdPtr;
   logic [1:0] count;        // 0..2 entries held
   logic       doPush;
   logic       doPop;

   assign doPush = push && !full;    // Drop when full
   assign doPop  = pop && !empty;

   // Pointers and occupancy
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         wrPtr <= 1'b0;
         rdPtr <= 1'b0;
         count <= 2'd0;
      end else begin
         if (doPush) wrPtr <= ~wrPtr;
         if (doPop)  rdPtr <= ~rdPtr;
         count <= count + {1'b0, doPush} - {1'b0, doPop};
      end
   end

   always_ff @(posedge Clock) begin
      if (doPush) begin
         entry[wrPtr] <= pushData;
      end
   end

   assign popData    = entry[rdPtr];       // Show-ahead
   assign full       = (count == 2'd2);
   assign almostFull = (count != 2'd0);    // One slot of margin left
   assign empty      = (count == 2'd0);

endmodule

`default_nettype wire

// File: hdl/dualPortRam.sv
`timescale 1ns/1ps
`default_nettype none

module dualPortRam (
   input  wire                                   Clock,
   // Port A, byte writable
   input  var   logic [tileMemPkg::MemAdrsW-1:0] adrsA,
   input  var   tileMemPkg::word                 wrDataA,
   input  var   tileMemPkg::byteEn               byteEnA,
   input  wire                                   wrEnA,
   output tileMemPkg::word                       rdDataA,
   // Port B, whole words
   input  var   logic [tileMemPkg::MemAdrsW-1:0] adrsB,
   input  var   tileMemPkg::word                 wrDataB,
   input  wire                                   wrEnB,
   output tileMemPkg::word                       rdDataB
);
   import tileMemPkg::*;

   word mem [2**MemAdrsW];   // Behavioral storage

   // Writes, A per lane and B full word
   always_ff @(posedge Clock) begin
      for (int i = 0; i < 4; i++) begin
         if (wrEnA && byteEnA[i]) begin
            mem[adrsA][8*i +: 8] <= wrDataA[8*i +: 8];
         end
      end
      if (wrEnB) begin
         mem[adrsB] <= wrDataB;
      end
   end

   // Registered reads, one cycle latency
   always_ff @(posedge Clock) begin
      rdDataA <= mem[adrsA];
      rdDataB <= mem[adrsB];
   end

endmodule

`default_nettype wire

// File: hdl/tileMemPkg.sv
`default_nettype none

package tileMemPkg;

   // ================================================
   // Widths with a meaning
   // ================================================
   typedef logic [31:0] word;     // Data or address word
   typedef logic [3:0]  byteEn;   // One enable per byte lane
   typedef logic [7:0]  tileId;   // Tile number, address bits 31:24
   typedef logic [1:0]  opcode;   // Fabric transaction kind

   // Fabric opcodes
   localparam opcode OpRd    = 2'd0;
   localparam opcode OpWr    = 2'd1;
   localparam opcode OpRdRsp = 2'd2;

   // ================================================
   // Address map
   // ================================================
   localparam int RegionLsb = 20;
   localparam int RegionMsb = 23;

   localparam logic [3:0] IMemRegion = 4'd0;
   localparam logic [3:0] DMemRegion = 4'd1;

   localparam int  MemAdrsW   = 10;            // 1K words per memory
   localparam word WhoAmIAddr = 32'h00FF_FFFF; // Returns local tile id

   // ================================================
   // Bundles
   // ================================================
   // One fabric transaction, 74 bits
   typedef struct packed {
      word   address;
      word   data;
      opcode op;
      tileId requestorId;
   } tileTrans;

   // Fabric write towards the local memories
   typedef struct packed {
      word  adrs;
      word  data;
      logic iMemWrEn;
      logic dMemWrEn;
   } fabWrite;

   // Remote read tracker
   typedef enum logic {
      Idle,
      WaitRsp
   } rdState;

endpackage

`default_nettype wire
